/* pad_cfg_pkg.sv */
// Pad counts, attribute layout and fixed pad tables for the pad I/O path
// MIO pads sit in the low bits of every combined vector, DIO pads above them
// The variant and connect tables are fixed at build time and not programmable
package pad_cfg_pkg;

  //////////////////////////////////////////////////
  // Pad counts
  //////////////////////////////////////////////////

  localparam int unsigned NMioPads = 16;                  // Muxed pads
  localparam int unsigned NDioPads = 6;                   // Dedicated pads
  localparam int unsigned NumIOs   = NMioPads + NDioPads; // MIO low, DIO high

  //////////////////////////////////////////////////
  // Attribute layout
  //////////////////////////////////////////////////

  // Bit 0 inverts in both directions, bit 1 selects virtual open drain
  localparam int unsigned AttrDw       = 2;
  localparam int unsigned AttrInvBit   = 0; // Invert
  localparam int unsigned AttrVodBit   = 1; // Virtual open drain

  //////////////////////////////////////////////////
  // Pad variants
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PadBidir     = 2'd0, // Full bidirectional
    PadInputOnly = 2'd1, // Receiver only, never drives
    PadTolerant  = 2'd2, // Bidir, higher voltage tolerant
    PadOpenDrain = 2'd3  // Pulls low or floats
  } pad_variant_e;

  // Index 0 is the first entry
  localparam pad_variant_e PadVariant [NumIOs] = '{
    PadBidir,     PadBidir,     PadBidir,     PadBidir,     // MIO 0-3
    PadOpenDrain, PadOpenDrain, PadOpenDrain, PadOpenDrain, // MIO 4-7
    PadBidir,     PadBidir,     PadBidir,     PadBidir,     // MIO 8-11
    PadOpenDrain, PadOpenDrain, PadOpenDrain, PadOpenDrain, // MIO 12-15
    PadTolerant,                                            // DIO 0
    PadBidir,                                               // DIO 1, not bonded
    PadBidir,     PadBidir,                                 // DIO 2-3
    PadInputOnly, PadInputOnly                              // DIO 4-5
  };

  //////////////////////////////////////////////////
  // Connect masks
  //////////////////////////////////////////////////

  localparam int unsigned DioUnconnIdx = 1; // DIO pad with no bond

  // A 0 bit marks a pad that is not connected
  localparam logic [NumIOs-1:0] ConnectIn =
      ~({{(NumIOs-1){1'b0}}, 1'b1} << (NMioPads + DioUnconnIdx));
  localparam logic [NumIOs-1:0] ConnectOut =
      ~({{(NumIOs-1){1'b0}}, 1'b1} << (NMioPads + DioUnconnIdx));

endpackage : pad_cfg_pkg

/* jtag_pin_pkg.sv */
// JTAG pin placement on the MIO pads and the values seen while JTAG owns them
// Indices are into the combined NumIOs vector
package jtag_pin_pkg;

  //////////////////////////////////////////////////
  // Pin indices
  //////////////////////////////////////////////////

  localparam int unsigned JtagEnIdx = 9;  // MIO 9, strap that selects JTAG
  localparam int unsigned TckIdx    = 13; // MIO 13
  localparam int unsigned TmsIdx    = 10; // MIO 10
  localparam int unsigned TrstIdx   = 14; // MIO 14
  localparam int unsigned TdiIdx    = 12; // MIO 12
  localparam int unsigned TdoIdx    = 11; // MIO 11

  localparam logic JtagEnPolarity = 1'b1; // Strap level for JTAG mode

  //////////////////////////////////////////////////
  // Idle levels toward the TAP
  //////////////////////////////////////////////////

  localparam logic TckIdle   = 1'b0; // Clock parked low
  localparam logic TmsIdle   = 1'b0;
  localparam logic TrstNIdle = 1'b0; // TAP held in reset
  localparam logic TdiIdle   = 1'b0;

  //////////////////////////////////////////////////
  // Core-side tie-offs
  //////////////////////////////////////////////////

  localparam int unsigned DioSpiCsbIdx = 4; // SPI chip select, active low

  // Core sees these on JTAG pads, chip select held inactive
  localparam logic [pad_cfg_pkg::NumIOs-1:0] TieOffValues =
      {{(pad_cfg_pkg::NumIOs-1){1'b0}}, 1'b1} << (pad_cfg_pkg::NMioPads + DioSpiCsbIdx);

endpackage : jtag_pin_pkg

/* pad_in_stage.sv */
`timescale 1ns/1ns
// Pad levels take two cycles to reach pad_in_sync_o
// Invert is applied after the flops, so attribute changes show at once
module pad_in_stage (
  input  logic                                                    clk_i,         // Core clock
  input  logic                                                    arst_n_i,      // Async, low
  input  logic [pad_cfg_pkg::NumIOs-1:0]                          pad_in_i,      // Raw pads
  input  logic [pad_cfg_pkg::NumIOs-1:0][pad_cfg_pkg::AttrDw-1:0] attr_i,        // Per pad
  output logic [pad_cfg_pkg::NumIOs-1:0]                          pad_in_sync_o  // To mux
);

  logic [pad_cfg_pkg::NumIOs-1:0] sync_q1;     // First sync flop
  logic [pad_cfg_pkg::NumIOs-1:0] sync_q2;     // Second sync flop
  logic [pad_cfg_pkg::NumIOs-1:0] sync_masked; // After connect mask
  logic [pad_cfg_pkg::NumIOs-1:0] in_inv;      // Invert bits only

  //////////////////////////////////////////////////
  // Synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i; // Possibly metastable
      sync_q2 <= sync_q1;  // Settled
    end
  end

  //////////////////////////////////////////////////
  // Mask and invert
  //////////////////////////////////////////////////

  assign sync_masked = sync_q2 & pad_cfg_pkg::ConnectIn; // Unbonded pads read 0

  always_comb begin
    for (int i = 0; i < pad_cfg_pkg::NumIOs; i++) begin
      in_inv[i] = attr_i[i][pad_cfg_pkg::AttrInvBit];
    end
  end

  assign pad_in_sync_o = sync_masked ^ in_inv;

  // Unbonded pads must never leak a 1 past the mask, whatever the pad does
  for (genvar i = 0; i < pad_cfg_pkg::NumIOs; i++) begin : gen_unconn_chk
    if (!pad_cfg_pkg::ConnectIn[i]) begin : gen_chk
      a_unconn_zero : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !sync_masked[i]
      );
    end
  end

endmodule : pad_in_stage

/* jtag_overlay_mux.sv */
`timescale 1ns/1ns
// Purely combinational overlay, clock and reset only feed the checks
// JTAG mode follows the synchronized strap, so it lags the pad by two cycles
module jtag_overlay_mux (
  input  logic                           clk_i,         // Checks only
  input  logic                           arst_n_i,      // Checks only
  input  logic [pad_cfg_pkg::NumIOs-1:0] pad_in_sync_i, // From input stage
  input  logic [pad_cfg_pkg::NumIOs-1:0] out_core_i,    // Core drive
  input  logic [pad_cfg_pkg::NumIOs-1:0] oe_core_i,     // Core enables
  input  logic                           jtag_tdo_i,    // From TAP
  output logic [pad_cfg_pkg::NumIOs-1:0] in_core_o,     // To core
  output logic [pad_cfg_pkg::NumIOs-1:0] out_mux_o,     // To output stage
  output logic [pad_cfg_pkg::NumIOs-1:0] oe_mux_o,      // To output stage
  output logic                           jtag_tck_o,
  output logic                           jtag_tms_o,
  output logic                           jtag_trst_n_o,
  output logic                           jtag_tdi_o
);

  logic jtag_en; // Overlay active

  assign jtag_en = (pad_in_sync_i[jtag_pin_pkg::JtagEnIdx] == jtag_pin_pkg::JtagEnPolarity);

  //////////////////////////////////////////////////
  // Pads toward the TAP
  //////////////////////////////////////////////////

  always_comb begin
    if (jtag_en) begin
      jtag_tck_o    = pad_in_sync_i[jtag_pin_pkg::TckIdx];
      jtag_tms_o    = pad_in_sync_i[jtag_pin_pkg::TmsIdx];
      jtag_trst_n_o = pad_in_sync_i[jtag_pin_pkg::TrstIdx];
      jtag_tdi_o    = pad_in_sync_i[jtag_pin_pkg::TdiIdx];
    end else begin
      jtag_tck_o    = jtag_pin_pkg::TckIdle;
      jtag_tms_o    = jtag_pin_pkg::TmsIdle;
      jtag_trst_n_o = jtag_pin_pkg::TrstNIdle; // Keeps TAP in reset
      jtag_tdi_o    = jtag_pin_pkg::TdiIdle;
    end
  end

  //////////////////////////////////////////////////
  // Core side and pad drive
  //////////////////////////////////////////////////

  always_comb begin
    in_core_o = pad_in_sync_i; // Default pass-through
    out_mux_o = out_core_i;
    oe_mux_o  = oe_core_i;
    if (jtag_en) begin
      // Core sees tie-offs on the pads JTAG has taken
      in_core_o[jtag_pin_pkg::TckIdx]  = jtag_pin_pkg::TieOffValues[jtag_pin_pkg::TckIdx];
      in_core_o[jtag_pin_pkg::TmsIdx]  = jtag_pin_pkg::TieOffValues[jtag_pin_pkg::TmsIdx];
      in_core_o[jtag_pin_pkg::TrstIdx] = jtag_pin_pkg::TieOffValues[jtag_pin_pkg::TrstIdx];
      in_core_o[jtag_pin_pkg::TdiIdx]  = jtag_pin_pkg::TieOffValues[jtag_pin_pkg::TdiIdx];
      in_core_o[jtag_pin_pkg::TdoIdx]  = jtag_pin_pkg::TieOffValues[jtag_pin_pkg::TdoIdx];
      out_mux_o[jtag_pin_pkg::TdoIdx]  = jtag_tdo_i; // TAP owns TDO
      oe_mux_o[jtag_pin_pkg::TdoIdx]   = 1'b1;
      oe_mux_o[jtag_pin_pkg::TckIdx]   = 1'b0; // Inputs only in JTAG mode
      oe_mux_o[jtag_pin_pkg::TmsIdx]   = 1'b0;
      oe_mux_o[jtag_pin_pkg::TrstIdx]  = 1'b0;
      oe_mux_o[jtag_pin_pkg::TdiIdx]   = 1'b0;
    end
  end

  // TAP must stay in reset whenever the strap is off
  a_trst_idle : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !jtag_en |-> !jtag_trst_n_o
  );

  // Core may never fight the external TCK driver
  a_tck_no_drive : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    jtag_en |-> !oe_mux_o[jtag_pin_pkg::TckIdx]
  );

endmodule : jtag_overlay_mux

/* pad_out_stage.sv */
`timescale 1ns/1ns
// Pad drive is registered, so every change shows one cycle later
// Open drain pads only ever pull low, input-only and unbonded pads never drive
module pad_out_stage (
  input  logic                                                    clk_i,     // Core clock
  input  logic                                                    arst_n_i,  // Async, low
  input  logic [pad_cfg_pkg::NumIOs-1:0]                          out_i,     // From mux
  input  logic [pad_cfg_pkg::NumIOs-1:0]                          oe_i,      // From mux
  input  logic [pad_cfg_pkg::NumIOs-1:0][pad_cfg_pkg::AttrDw-1:0] attr_i,    // Per pad
  output logic [pad_cfg_pkg::NumIOs-1:0]                          pad_out_o, // To pads
  output logic [pad_cfg_pkg::NumIOs-1:0]                          pad_oe_o   // To pads
);

  logic [pad_cfg_pkg::NumIOs-1:0] out_d; // Next pad value
  logic [pad_cfg_pkg::NumIOs-1:0] oe_d;  // Next pad enable

  //////////////////////////////////////////////////
  // Drive rules
  //////////////////////////////////////////////////

  always_comb begin
    logic inv_val; // Value after invert
    logic od;      // Open drain by variant or attribute
    for (int i = 0; i < pad_cfg_pkg::NumIOs; i++) begin
      inv_val = out_i[i] ^ attr_i[i][pad_cfg_pkg::AttrInvBit];
      od      = (pad_cfg_pkg::PadVariant[i] == pad_cfg_pkg::PadOpenDrain) ||
                attr_i[i][pad_cfg_pkg::AttrVodBit];
      if (od) begin
        out_d[i] = 1'b0;                 // Pull low only
        oe_d[i]  = oe_i[i] & ~inv_val;   // Float on 1
      end else begin
        out_d[i] = inv_val;              // Bidir and tolerant
        oe_d[i]  = oe_i[i];
      end
      if ((pad_cfg_pkg::PadVariant[i] == pad_cfg_pkg::PadInputOnly) ||
          !pad_cfg_pkg::ConnectOut[i]) begin
        out_d[i] = 1'b0; // No driver
        oe_d[i]  = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pad_out_o <= '0; // All pads released
      pad_oe_o  <= '0;
    end else begin
      pad_out_o <= out_d;
      pad_oe_o  <= oe_d;
    end
  end

  for (genvar i = 0; i < pad_cfg_pkg::NumIOs; i++) begin : gen_drive_chk
    // Open drain decided by last cycle's attribute, since the drive is registered
    a_od_no_high : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      ((pad_cfg_pkg::PadVariant[i] == pad_cfg_pkg::PadOpenDrain) ||
       $past(attr_i[i][pad_cfg_pkg::AttrVodBit])) |-> !(pad_out_o[i] && pad_oe_o[i])
    );
    if (pad_cfg_pkg::PadVariant[i] == pad_cfg_pkg::PadInputOnly) begin : gen_in_only
      a_in_only_no_oe : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !pad_oe_o[i]
      );
    end
  end

endmodule : pad_out_stage

/* pad_io_top.sv */
`timescale 1ns/1ns
// Pad-side I/O path with separate out, oe and in ports per pad
// Inputs arrive two cycles late, outputs one cycle late
module pad_io_top (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n_i,
  // Core side
  input  logic [pad_cfg_pkg::NMioPads-1:0]                          mio_out_i,
  input  logic [pad_cfg_pkg::NMioPads-1:0]                          mio_oe_i,
  input  logic [pad_cfg_pkg::NMioPads-1:0][pad_cfg_pkg::AttrDw-1:0] mio_attr_i,
  input  logic [pad_cfg_pkg::NDioPads-1:0]                          dio_out_i,
  input  logic [pad_cfg_pkg::NDioPads-1:0]                          dio_oe_i,
  input  logic [pad_cfg_pkg::NDioPads-1:0][pad_cfg_pkg::AttrDw-1:0] dio_attr_i,
  output logic [pad_cfg_pkg::NMioPads-1:0]                          mio_in_o,
  output logic [pad_cfg_pkg::NDioPads-1:0]                          dio_in_o,
  // Pad side
  input  logic [pad_cfg_pkg::NMioPads-1:0]                          mio_pad_in_i,
  input  logic [pad_cfg_pkg::NDioPads-1:0]                          dio_pad_in_i,
  output logic [pad_cfg_pkg::NMioPads-1:0]                          mio_pad_out_o,
  output logic [pad_cfg_pkg::NMioPads-1:0]                          mio_pad_oe_o,
  output logic [pad_cfg_pkg::NDioPads-1:0]                          dio_pad_out_o,
  output logic [pad_cfg_pkg::NDioPads-1:0]                          dio_pad_oe_o,
  // JTAG side
  output logic                                                      jtag_tck_o,
  output logic                                                      jtag_tms_o,
  output logic                                                      jtag_trst_n_o,
  output logic                                                      jtag_tdi_o,
  input  logic                                                      jtag_tdo_i
);

  //////////////////////////////////////////////////
  // Joined vectors, DIO above MIO
  //////////////////////////////////////////////////

  logic [pad_cfg_pkg::NumIOs-1:0][pad_cfg_pkg::AttrDw-1:0] attr_all; // All attributes
  logic [pad_cfg_pkg::NumIOs-1:0] pad_in_sync; // Synced, masked, inverted
  logic [pad_cfg_pkg::NumIOs-1:0] in_core;     // Back to core
  logic [pad_cfg_pkg::NumIOs-1:0] out_mux;     // After overlay
  logic [pad_cfg_pkg::NumIOs-1:0] oe_mux;
  logic [pad_cfg_pkg::NumIOs-1:0] pad_out;     // Registered drive
  logic [pad_cfg_pkg::NumIOs-1:0] pad_oe;

  assign attr_all = {dio_attr_i, mio_attr_i};

  pad_in_stage u_pad_in_stage (
    .clk_i         ( clk_i                        ),
    .arst_n_i      ( arst_n_i                     ),
    .pad_in_i      ( {dio_pad_in_i, mio_pad_in_i} ),
    .attr_i        ( attr_all                     ),
    .pad_in_sync_o ( pad_in_sync                  )
  );

  jtag_overlay_mux u_jtag_overlay_mux (
    .clk_i         ( clk_i                  ),
    .arst_n_i      ( arst_n_i               ),
    .pad_in_sync_i ( pad_in_sync            ),
    .out_core_i    ( {dio_out_i, mio_out_i} ),
    .oe_core_i     ( {dio_oe_i, mio_oe_i}   ),
    .jtag_tdo_i    ( jtag_tdo_i             ),
    .in_core_o     ( in_core                ),
    .out_mux_o     ( out_mux                ),
    .oe_mux_o      ( oe_mux                 ),
    .jtag_tck_o    ( jtag_tck_o             ),
    .jtag_tms_o    ( jtag_tms_o             ),
    .jtag_trst_n_o ( jtag_trst_n_o          ),
    .jtag_tdi_o    ( jtag_tdi_o             )
  );

  pad_out_stage u_pad_out_stage (
    .clk_i     ( clk_i    ),
    .arst_n_i  ( arst_n_i ),
    .out_i     ( out_mux  ),
    .oe_i      ( oe_mux   ),
    .attr_i    ( attr_all ),
    .pad_out_o ( pad_out  ),
    .pad_oe_o  ( pad_oe   )
  );

  //////////////////////////////////////////////////
  // Split back into MIO and DIO
  //////////////////////////////////////////////////

  assign {dio_in_o, mio_in_o}           = in_core;
  assign {dio_pad_out_o, mio_pad_out_o} = pad_out;
  assign {dio_pad_oe_o, mio_pad_oe_o}   = pad_oe;

endmodule : pad_io_top

/* tb_clk_gen.sv */
`timescale 1ns/1ns
// Free-running 8 ns clock, reset low for the first three cycles
// Reset lets go on a falling edge, clear of the sampling edge
module tb_clk_gen (
  output logic clk_o,   // 125 MHz
  output logic arst_n_o // Async, low
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o; // Half of 8 ns
  end

  initial begin
    arst_n_o = 1'b0;
    #24;             // Three full cycles
    arst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

/* tb_pad_io.sv */
`timescale 1ns/1ns
// Each row is held 4 cycles, enough for the 2-cycle input sync and the
// 3-cycle strap to pad path, then sampled on the falling edge
module tb_pad_io;

  typedef logic [pad_cfg_pkg::NumIOs-1:0] vec_t;
  typedef logic [pad_cfg_pkg::NumIOs*pad_cfg_pkg::AttrDw-1:0] attr_t; // Pad i at [2i+1:2i]

  typedef struct packed {
    vec_t       out;      // Core drive, DIO above MIO
    vec_t       oe;
    attr_t      attr;
    vec_t       pin;      // Pad levels
    logic       tdo;
    vec_t       exp_pout;
    vec_t       exp_poe;
    vec_t       exp_cin;  // Core side
    logic [3:0] exp_jtag; // {tck, tms, trst_n, tdi}
  } row_t;

  localparam int NumTableRows = 6;
  localparam int NumRandRows  = 32;
  localparam int WatchdogNs   = (NumTableRows + NumRandRows + 8) * 4 * 8;

  logic clk;
  logic arst_n;
  logic [pad_cfg_pkg::NMioPads-1:0]                          mio_out, mio_oe, mio_pad_in;
  logic [pad_cfg_pkg::NMioPads-1:0][pad_cfg_pkg::AttrDw-1:0] mio_attr;
  logic [pad_cfg_pkg::NDioPads-1:0]                          dio_out, dio_oe, dio_pad_in;
  logic [pad_cfg_pkg::NDioPads-1:0][pad_cfg_pkg::AttrDw-1:0] dio_attr;
  logic [pad_cfg_pkg::NMioPads-1:0]                          mio_in, mio_pad_out, mio_pad_oe;
  logic [pad_cfg_pkg::NDioPads-1:0]                          dio_in, dio_pad_out, dio_pad_oe;
  logic jtag_tck, jtag_tms, jtag_trst_n, jtag_tdi, jtag_tdo;

  int          err_count  = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          test_num   = 0;
  logic [15:0] lfsr_q     = 16'd2; // Seed

  //////////////////////////////////////////////////
  // Directed rows, expected values worked by hand
  //////////////////////////////////////////////////

  row_t table_rows [NumTableRows] = '{
    // Bidir pads follow core, JTAG off
    '{22'h0C0A05, 22'h0F0F0F, 44'h000_0000_0000, 22'h050003, 1'b0,
      22'h0C0A05, 22'h0D0F0F, 22'h050003, 4'b0000},
    // Invert on pads 0, 1, 8, 16, 18
    '{22'h0C0A05, 22'h0F0F0F, 44'h011_0001_0005, 22'h050003, 1'b0,
      22'h090B06, 22'h0D0F0F, 22'h000100, 4'b0000},
    // Open drain by variant and by attr on pads 2, 3
    '{22'h320054, 22'h3200FC, 44'h000_0000_00A0, 22'h320000, 1'b0,
      22'h000000, 22'h0000A8, 22'h300000, 4'b0000},
    // Strap on, TDO driven high
    '{22'h002C01, 22'h007C01, 44'h000_0000_0000, 22'h106E01, 1'b1,
      22'h000C01, 22'h000801, 22'h100201, 4'b1110},
    // Strap on, TDO low over core 1
    '{22'h000800, 22'h000800, 44'h000_0000_0000, 22'h005200, 1'b0,
      22'h000000, 22'h000800, 22'h000200, 4'b0011},
    // Strap off, TAP back to idle
    '{22'h000800, 22'h000800, 44'h000_0000_0000, 22'h007400, 1'b0,
      22'h000800, 22'h000800, 22'h007400, 4'b0000}
  };

  string row_names [NumTableRows] = '{
    "bidir pass-through", "invert attribute", "open drain and input-only",
    "jtag on tdo high", "jtag on tdo low", "jtag off again"
  };

  tb_clk_gen u_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  pad_io_top i_pad_io_top (
    .clk_i         ( clk         ),
    .arst_n_i      ( arst_n      ),
    .mio_out_i     ( mio_out     ),
    .mio_oe_i      ( mio_oe      ),
    .mio_attr_i    ( mio_attr    ),
    .dio_out_i     ( dio_out     ),
    .dio_oe_i      ( dio_oe      ),
    .dio_attr_i    ( dio_attr    ),
    .mio_in_o      ( mio_in      ),
    .dio_in_o      ( dio_in      ),
    .mio_pad_in_i  ( mio_pad_in  ),
    .dio_pad_in_i  ( dio_pad_in  ),
    .mio_pad_out_o ( mio_pad_out ),
    .mio_pad_oe_o  ( mio_pad_oe  ),
    .dio_pad_out_o ( dio_pad_out ),
    .dio_pad_oe_o  ( dio_pad_oe  ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_trst_n_o ( jtag_trst_n ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_tdo_i    ( jtag_tdo    )
  );

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q); // One step per bit
      v[b]   = lfsr_q[0];
    end
  endtask

  // Steady-state response of the whole path to one row of inputs
  function automatic void predict(input vec_t out_v, input vec_t oe_v, input attr_t attr_v,
                                  input vec_t pin_v, input logic tdo_v,
                                  output vec_t pout, output vec_t poe, output vec_t cin,
                                  output logic [3:0] jtag);
    int unsigned jpads [5] = '{jtag_pin_pkg::TckIdx, jtag_pin_pkg::TmsIdx,
                               jtag_pin_pkg::TrstIdx, jtag_pin_pkg::TdiIdx,
                               jtag_pin_pkg::TdoIdx};
    vec_t inv, mo, moe;
    logic jen, v, od;
    for (int i = 0; i < pad_cfg_pkg::NumIOs; i++) begin
      inv[i] = attr_v[i*pad_cfg_pkg::AttrDw + pad_cfg_pkg::AttrInvBit];
    end
    cin  = (pin_v & pad_cfg_pkg::ConnectIn) ^ inv; // Mask, then invert
    jen  = (cin[jtag_pin_pkg::JtagEnIdx] == jtag_pin_pkg::JtagEnPolarity);
    jtag = 4'b0000;                                // Idle, TAP in reset
    mo   = out_v;
    moe  = oe_v;
    if (jen) begin
      jtag = {cin[jtag_pin_pkg::TckIdx], cin[jtag_pin_pkg::TmsIdx],
              cin[jtag_pin_pkg::TrstIdx], cin[jtag_pin_pkg::TdiIdx]};
      foreach (jpads[k]) begin
        cin[jpads[k]] = jtag_pin_pkg::TieOffValues[jpads[k]];
        moe[jpads[k]] = 1'b0;                      // TAP inputs released
      end
      mo[jtag_pin_pkg::TdoIdx]  = tdo_v;
      moe[jtag_pin_pkg::TdoIdx] = 1'b1;
    end
    for (int i = 0; i < pad_cfg_pkg::NumIOs; i++) begin
      v  = mo[i] ^ inv[i];
      od = (pad_cfg_pkg::PadVariant[i] == pad_cfg_pkg::PadOpenDrain) ||
           attr_v[i*pad_cfg_pkg::AttrDw + pad_cfg_pkg::AttrVodBit];
      pout[i] = od ? 1'b0 : v;                     // Open drain pulls low only
      poe[i]  = od ? (moe[i] & ~v) : moe[i];
      if ((pad_cfg_pkg::PadVariant[i] == pad_cfg_pkg::PadInputOnly) ||
          !pad_cfg_pkg::ConnectOut[i]) begin
        pout[i] = 1'b0;
        poe[i]  = 1'b0;
      end
    end
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    test_num++;
    if (err_count == errs_before) begin
      pass_count++;
      $display("Test %0d %s: passed", test_num, name);
    end else begin
      fail_count++;
      $display("Test %0d %s: failed", test_num, name);
    end
  endtask

  task automatic run_row(input string name, input row_t r);
    int errs_before;
    errs_before = err_count;
    @(posedge clk);
    {dio_out, mio_out}       <= r.out;
    {dio_oe, mio_oe}         <= r.oe;
    {dio_attr, mio_attr}     <= r.attr;
    {dio_pad_in, mio_pad_in} <= r.pin;
    jtag_tdo                 <= r.tdo;
    repeat (3) @(posedge clk);
    @(negedge clk);                                 // Settled
    check_value({name, " pad out"}, 64'({dio_pad_out, mio_pad_out}), 64'(r.exp_pout));
    check_value({name, " pad oe"}, 64'({dio_pad_oe, mio_pad_oe}), 64'(r.exp_poe));
    check_value({name, " core in"}, 64'({dio_in, mio_in}), 64'(r.exp_cin));
    check_value({name, " jtag"}, 64'({jtag_tck, jtag_tms, jtag_trst_n, jtag_tdi}),
                64'(r.exp_jtag));
    close_test(name, errs_before);
  endtask

  task automatic make_random_row(output row_t r);
    logic [63:0] bits;
    take_bits(pad_cfg_pkg::NumIOs, bits);
    r.out = bits[pad_cfg_pkg::NumIOs-1:0];
    take_bits(pad_cfg_pkg::NumIOs, bits);
    r.oe = bits[pad_cfg_pkg::NumIOs-1:0];
    take_bits(pad_cfg_pkg::NumIOs*pad_cfg_pkg::AttrDw, bits);
    r.attr = bits[pad_cfg_pkg::NumIOs*pad_cfg_pkg::AttrDw-1:0];
    take_bits(pad_cfg_pkg::NumIOs, bits);
    r.pin = bits[pad_cfg_pkg::NumIOs-1:0];             // Strap random too
    take_bits(1, bits);
    r.tdo = bits[0];
    predict(r.out, r.oe, r.attr, r.pin, r.tdo, r.exp_pout, r.exp_poe, r.exp_cin, r.exp_jtag);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    row_t r;
    int   errs_before;
    mio_out    <= '0;
    mio_oe     <= '0;
    mio_attr   <= '0;
    dio_out    <= '0;
    dio_oe     <= '0;
    dio_attr   <= '0;
    mio_pad_in <= '0;
    dio_pad_in <= '0;
    jtag_tdo   <= 1'b0;

    @(negedge clk);                                  // Still in reset
    errs_before = err_count;
    check_value("reset pad out", 64'({dio_pad_out, mio_pad_out}), 64'(0));
    check_value("reset pad oe", 64'({dio_pad_oe, mio_pad_oe}), 64'(0));
    check_value("reset core in", 64'({dio_in, mio_in}), 64'(0));
    check_value("reset jtag", 64'({jtag_tck, jtag_tms, jtag_trst_n, jtag_tdi}), 64'(0));
    close_test("reset", errs_before);
    wait (arst_n);

    for (int i = 0; i < NumTableRows; i++) begin
      run_row(row_names[i], table_rows[i]);
    end
    for (int i = 0; i < NumRandRows; i++) begin
      make_random_row(r);
      run_row($sformatf("random %0d", i), r);
    end

    $display("Tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WatchdogNs);
    $display("Timeout: run did not finish within %0d ns", WatchdogNs);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule : tb_pad_io

/* filelist.f */
pad_cfg_pkg.sv
jtag_pin_pkg.sv
pad_in_stage.sv
jtag_overlay_mux.sv
pad_out_stage.sv
pad_io_top.sv
tb_clk_gen.sv
tb_pad_io.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= tb_pad_io
FILELIST ?= filelist.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
